/* nes_glue_pkg.sv */
////////////////////
// shared types for the softcore memory bridge and the NES joypad ports
// button layout is SNES order, lower byte is the NES set with A in bit 0
// memory words are 16 bits, softcore words 32 bits
////////////////////

package nes_glue_pkg;

    localparam int NUM_PLAYERS = 2;

    // softcore side
    typedef logic [22:0] rv_addr_t;   // byte address
    typedef logic [31:0] rv_word_t;
    typedef logic [3:0]  rv_strb_t;   // all zero means read

    // memory side
    typedef logic [19:0] mem_addr_t;  // {word addr[20:2], half}
    typedef logic [15:0] mem_half_t;
    typedef logic [1:0]  mem_ds_t;

    typedef struct packed {
        rv_addr_t addr;
        rv_word_t wdata;
        rv_strb_t strb;
    } rv_req_t;

    typedef struct packed {
        mem_addr_t addr;
        mem_half_t wdata;
        mem_ds_t   ds;
        logic      we;
    } mem_req_t;

    // R L X A RT LT DN UP START SELECT Y B
    typedef logic [11:0] snes_btns_t;
    typedef logic [7:0]  nes_btns_t;

    typedef struct packed {
        logic                   strobe;   // shared by both players
        logic [NUM_PLAYERS-1:0] joy_clk;
    } pad_bus_t;

    typedef enum logic [2:0] {
        IDLE_REQ0,
        WAIT0_REQ1,
        DATA0,
        WAIT1,
        DATA1
    } bridge_state_t;

    localparam int BTN_A      = 0;
    localparam int BTN_B      = 1;
    localparam int BTN_AUTO_A = 8;
    localparam int BTN_AUTO_B = 9;

endpackage

/* autofire.sv */
////////////////////
// square wave while the button is held, first half-wave high
// AUTOFIRE_PERIOD is cycles per half-wave, at least 1
////////////////////

`timescale 1ns/10ps

module autofire #(
    parameter int AUTOFIRE_PERIOD = 2 ** 20
) (
    input  logic clk,
    input  logic sys_resetn,
    input  logic i_btn,
    output logic o_fire
);

    localparam int CNT_W = $clog2(AUTOFIRE_PERIOD + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!sys_resetn || !i_btn) begin
            cnt    <= '0;
            o_fire <= 1'b0;
        end else if (cnt == '0) begin
            o_fire <= ~o_fire;   // flips high on the first held cycle
            cnt    <= CNT_W'(AUTOFIRE_PERIOD - 1);
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

/* joypad_port.sv */
////////////////////
// NES joypad shift register for one player
// loads every cycle while strobe is high, shifts on falling joy clock
// reads past bit 7 return 1
////////////////////

`timescale 1ns/10ps

module joypad_port #(
    parameter int AUTOFIRE_PERIOD = 2 ** 20
) (
    input  logic                     clk,
    input  logic                     sys_resetn,
    input  logic                     i_strobe,
    input  logic                     i_joy_clk,
    input  nes_glue_pkg::snes_btns_t i_btns,
    output logic                     o_data
);
    import nes_glue_pkg::*;

    logic      auto_a;
    logic      auto_b;
    logic      joy_clk_d;
    logic      clk_fall;
    nes_btns_t pad_byte;
    nes_btns_t shift_q;

    autofire #(
        .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
    ) u_auto_a (
        .clk       (clk),
        .sys_resetn(sys_resetn),
        .i_btn     (i_btns[BTN_AUTO_A]),
        .o_fire    (auto_a)
    );

    autofire #(
        .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
    ) u_auto_b (
        .clk       (clk),
        .sys_resetn(sys_resetn),
        .i_btn     (i_btns[BTN_AUTO_B]),
        .o_fire    (auto_b)
    );

    // autofire merged into A and B
    assign pad_byte = {i_btns[7:2], i_btns[BTN_B] | auto_b, i_btns[BTN_A] | auto_a};
    assign clk_fall = joy_clk_d & ~i_joy_clk;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            shift_q   <= '1;
            joy_clk_d <= 1'b0;
        end else begin
            joy_clk_d <= i_joy_clk;
            if (clk_fall) begin
                shift_q <= {1'b1, shift_q[7:1]};   // fill with 1s
            end else if (i_strobe) begin
                shift_q <= pad_byte;
            end
        end
    end

    assign o_data = shift_q[0];

endmodule

/* word_bridge.sv */
////////////////////
// 32-bit softcore requests to one or two 16-bit memory transactions
// memory side is a toggle handshake, done when ack equals toggle
// request must stay stable while i_rv_valid is high
////////////////////

`timescale 1ns/10ps

module word_bridge (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_rv_valid,
    input  nes_glue_pkg::rv_req_t i_rv_req,
    output logic                  o_rv_ready,
    output nes_glue_pkg::rv_word_t o_rv_rdata,
    output nes_glue_pkg::mem_req_t o_mem_req,
    output logic                  o_mem_toggle,
    input  logic                  i_mem_ack,
    input  nes_glue_pkg::mem_half_t i_mem_rdata
);
    import nes_glue_pkg::*;

    bridge_state_t state;
    mem_half_t     rdata0;       // lower half of a read
    logic          valid_r;
    logic          ready_d;
    logic          req_pending;
    logic          req_start;
    logic          req_seen;
    logic          is_write;
    logic          mem_done;

    // rising valid, or valid held into the cycle after ready
    assign req_start = i_rv_valid & (~valid_r | ready_d);
    assign req_seen  = req_start | req_pending;
    assign is_write  = |i_rv_req.strb;
    assign mem_done  = (i_mem_ack == o_mem_toggle);

    assign o_rv_rdata = {i_mem_rdata, rdata0};

    // memory request for one half of the current softcore word
    function automatic mem_req_t half_req(input logic upper);
        mem_req_t r;
        r.addr  = {i_rv_req.addr[20:2], upper};
        r.wdata = upper ? i_rv_req.wdata[31:16] : i_rv_req.wdata[15:0];
        r.we    = is_write;
        if (is_write) begin
            r.ds = upper ? i_rv_req.strb[3:2] : i_rv_req.strb[1:0];
        end else begin
            r.ds = 2'b11;
        end
        return r;
    endfunction

    ////////////////////
    // request FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state        <= IDLE_REQ0;
            o_rv_ready   <= 1'b0;
            o_mem_toggle <= 1'b0;
            valid_r      <= 1'b0;
            ready_d      <= 1'b0;
            req_pending  <= 1'b0;
        end else begin
            o_rv_ready  <= 1'b0;
            valid_r     <= i_rv_valid;
            ready_d     <= o_rv_ready;
            req_pending <= req_pending | req_start;

            case (state)
                IDLE_REQ0: begin
                    if (req_seen) begin
                        req_pending  <= 1'b0;
                        o_mem_toggle <= ~o_mem_toggle;
                        if (is_write && i_rv_req.strb[1:0] == 2'b00) begin
                            o_mem_req <= half_req(1'b1);   // upper half only
                            state     <= WAIT1;
                        end else begin
                            o_mem_req <= half_req(1'b0);
                            state     <= WAIT0_REQ1;
                        end
                    end
                end

                WAIT0_REQ1: begin
                    if (mem_done) begin
                        if (!is_write) begin
                            state <= DATA0;
                        end else if (i_rv_req.strb[3:2] == 2'b00) begin
                            // lower half only, finished
                            o_rv_ready <= 1'b1;
                            state      <= IDLE_REQ0;
                        end else begin
                            o_mem_toggle <= ~o_mem_toggle;
                            o_mem_req    <= half_req(1'b1);
                            state        <= WAIT1;
                        end
                    end
                end

                DATA0: begin
                    rdata0       <= i_mem_rdata;   // still valid, no toggle yet
                    o_mem_toggle <= ~o_mem_toggle;
                    o_mem_req    <= half_req(1'b1);
                    state        <= WAIT1;
                end

                WAIT1: begin
                    if (mem_done) begin
                        if (is_write) begin
                            o_rv_ready <= 1'b1;
                            state      <= IDLE_REQ0;
                        end else begin
                            state <= DATA1;
                        end
                    end
                end

                DATA1: begin
                    o_rv_ready <= 1'b1;   // upper half on i_mem_rdata
                    state      <= IDLE_REQ0;
                end

                default: state <= IDLE_REQ0;
            endcase
        end
    end

endmodule

/* nes_glue_top.sv */
////////////////////
// softcore memory bridge plus two NES joypad ports
// AUTOFIRE_PERIOD is passed down to every autofire unit
////////////////////

`timescale 1ns/10ps

module nes_glue_top #(
    parameter int AUTOFIRE_PERIOD = 2 ** 20
) (
    input  logic                     clk,
    input  logic                     sys_resetn,

    // softcore side
    input  logic                     i_rv_valid,
    input  nes_glue_pkg::rv_req_t    i_rv_req,
    output logic                     o_rv_ready,
    output nes_glue_pkg::rv_word_t   o_rv_rdata,

    // memory side, toggle handshake
    output nes_glue_pkg::mem_req_t   o_mem_req,
    output logic                     o_mem_toggle,
    input  logic                     i_mem_ack,
    input  nes_glue_pkg::mem_half_t  i_mem_rdata,

    // joypads
    input  nes_glue_pkg::pad_bus_t   i_pad,
    input  nes_glue_pkg::snes_btns_t i_btns [nes_glue_pkg::NUM_PLAYERS],
    output logic [nes_glue_pkg::NUM_PLAYERS-1:0] o_joy_data
);
    import nes_glue_pkg::*;

    word_bridge u_bridge (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_rv_valid  (i_rv_valid),
        .i_rv_req    (i_rv_req),
        .o_rv_ready  (o_rv_ready),
        .o_rv_rdata  (o_rv_rdata),
        .o_mem_req   (o_mem_req),
        .o_mem_toggle(o_mem_toggle),
        .i_mem_ack   (i_mem_ack),
        .i_mem_rdata (i_mem_rdata)
    );

    // one port per player, strobe shared
    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        joypad_port #(
            .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
        ) u_port (
            .clk       (clk),
            .sys_resetn(sys_resetn),
            .i_strobe  (i_pad.strobe),
            .i_joy_clk (i_pad.joy_clk[p]),
            .i_btns    (i_btns[p]),
            .o_data    (o_joy_data[p])
        );
    end

endmodule

/* tb_mem_model.sv */
////////////////////
// 16-bit memory behind the toggle handshake, simulation only
// acks 1 to 4 cycles after the toggle, i_delay 0 to 3 picks the extra wait
// contents start unknown, read only what was written
////////////////////

`timescale 1ns/10ps

module tb_mem_model (
    input  logic                    clk,
    input  logic                    sys_resetn,
    input  nes_glue_pkg::mem_req_t  i_req,
    input  logic                    i_toggle,
    input  logic [1:0]              i_delay,
    output logic                    o_ack,
    output nes_glue_pkg::mem_half_t o_rdata
);
    import nes_glue_pkg::*;

    mem_half_t  mem [2**20];
    logic       busy;
    logic [1:0] wait_cnt;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            o_ack <= 1'b0;
            busy  <= 1'b0;
        end else if (i_toggle != o_ack) begin
            if (busy ? (wait_cnt == 2'd0) : (i_delay == 2'd0)) begin
                busy  <= 1'b0;
                o_ack <= i_toggle;   // transaction done
                if (!i_req.we) begin
                    o_rdata <= mem[i_req.addr];
                end else begin
                    if (i_req.ds[1]) mem[i_req.addr][15:8] <= i_req.wdata[15:8];
                    if (i_req.ds[0]) mem[i_req.addr][7:0] <= i_req.wdata[7:0];
                end
            end else if (busy) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                busy     <= 1'b1;
                wait_cnt <= i_delay - 1'b1;
            end
        end
    end

endmodule

/* tb_nes_glue.sv */
////////////////////
// testbench for nes_glue_top with a random latency memory model
// AUTOFIRE_PERIOD 16 and a limit of 4000 cycles
////////////////////

`timescale 1ns/10ps

module tb_nes_glue;
    import nes_glue_pkg::*;

    localparam logic [31:0] SEED = 32'h4ae27507;

    logic                   clk;
    logic                   sys_resetn;
    logic                   rv_valid;
    rv_req_t                rv_req;
    logic                   rv_ready;
    rv_word_t               rv_rdata;
    mem_req_t               mem_req;
    mem_req_t               mem_req_q;
    logic                   mem_toggle;
    logic                   toggle_q = 1'b0;
    logic                   upper_next = 1'b0;
    logic                   mem_ack;
    mem_half_t              mem_rdata;
    logic [1:0]             mem_delay = 2'd0;
    pad_bus_t               pad;
    snes_btns_t             btns [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] joy_data;
    logic [31:0]            stim_rnd = SEED;
    logic [31:0]            dly_rnd = {SEED[15:0], SEED[31:16]};
    int                     cycle_cnt = 0;
    int                     toggle_cnt = 0;
    int                     ready_cnt = 0;
    rv_word_t               rdata;
    nes_btns_t              exp_byte [NUM_PLAYERS];
    logic                   fire_a;
    logic                   seen_hi;
    logic                   seen_lo;

    nes_glue_top #(.AUTOFIRE_PERIOD(16)) dut_i (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(rv_valid), .i_rv_req(rv_req), .o_rv_ready(rv_ready), .o_rv_rdata(rv_rdata),
        .o_mem_req(mem_req), .o_mem_toggle(mem_toggle), .i_mem_ack(mem_ack),
        .i_mem_rdata(mem_rdata), .i_pad(pad), .i_btns(btns), .o_joy_data(joy_data)
    );

    tb_mem_model mem_i (
        .clk(clk), .sys_resetn(sys_resetn), .i_req(mem_req), .i_toggle(mem_toggle),
        .i_delay(mem_delay), .o_ack(mem_ack), .o_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else
            abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    ////////////////////
    // per-cycle monitor on last cycle's values
    ////////////////////
    always @(posedge clk) begin
        mem_req_t exp_req;
        logic     upper;
        cycle_cnt++;
        if (cycle_cnt > 4000) abort_run("timeout, the run went past 4000 cycles");
        dly_rnd = xorshift(dly_rnd);
        mem_delay <= dly_rnd[1:0];
        toggle_q  <= mem_toggle;
        mem_req_q <= mem_req;
        if (sys_resetn) begin
            assert (rv_valid || !rv_ready) else
                abort_run("o_rv_ready rose while i_rv_valid was low");
            if (rv_ready) begin
                ready_cnt++;
                upper_next = 1'b0;   // next request starts over
            end
            if (mem_toggle != toggle_q) begin   // new transaction
                toggle_cnt++;
                exp_req.we    = |rv_req.strb;
                // lower half first unless a write has no low strobes
                upper         = upper_next || (exp_req.we && rv_req.strb[1:0] == 2'b00);
                upper_next    = 1'b1;
                exp_req.addr  = {rv_req.addr[20:2], upper};
                exp_req.wdata = upper ? rv_req.wdata[31:16] : rv_req.wdata[15:0];
                exp_req.ds    = exp_req.we ? (upper ? rv_req.strb[3:2] : rv_req.strb[1:0])
                                           : 2'b11;
                if (!exp_req.we) exp_req.wdata = mem_req.wdata;   // don't care on reads
                check_value("o_mem_req", mem_req, exp_req);
            end else if (mem_toggle != mem_ack) begin
                check_value("o_mem_req", mem_req, mem_req_q);    // held while pending
            end
        end
    end

    task automatic check_idle();
        check_value("o_rv_ready", rv_ready, 1'b0);
        check_value("o_mem_toggle", mem_toggle, 1'b0);
        check_value("o_joy_data", joy_data, 2'b11);
    endtask

    task automatic rv_access(input rv_addr_t a, input rv_word_t d, input rv_strb_t s,
                             input int exp_toggles, output rv_word_t rd);
        int toggles0;
        int ready0;
        @(negedge clk);
        toggles0 = toggle_cnt;
        ready0   = ready_cnt;
        @(posedge clk);
        rv_valid <= 1'b1;
        rv_req   <= '{addr: a, wdata: d, strb: s};
        do @(negedge clk); while (!rv_ready);
        rd = rv_rdata;
        @(posedge clk);
        rv_valid <= 1'b0;
        repeat (2) @(negedge clk);
        check_value("o_rv_ready pulse count", ready_cnt - ready0, 1);
        check_value("o_mem_toggle change count", toggle_cnt - toggles0, exp_toggles);
    endtask

    task automatic pad_strobe();
        @(posedge clk);
        pad.strobe <= 1'b1;
        @(posedge clk);
        pad.strobe <= 1'b0;
    endtask

    task automatic pad_edge(input int p);
        @(posedge clk);
        pad.joy_clk[p] <= 1'b1;
        @(posedge clk);
        pad.joy_clk[p] <= 1'b0;
        @(posedge clk);   // register shifts on this edge
    endtask

    // player 0 is clocked out before player 1 and both lines are checked each step
    task automatic read_pads();
        logic [9:0] exp [NUM_PLAYERS];
        for (int p = 0; p < NUM_PLAYERS; p++) exp[p] = {2'b11, exp_byte[p]};
        pad_strobe();
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            for (int i = 0; i < 11; i++) begin
                @(negedge clk);
                check_value("o_joy_data", joy_data, {exp[1][0], exp[0][0]});
                if (i < 10) begin
                    pad_edge(p);
                    exp[p] = {1'b1, exp[p][9:1]};
                end
            end
        end
    endtask

    task automatic sample_fire(output logic a);
        pad_strobe();
        @(negedge clk);
        a = joy_data[0];
        check_value("o_joy_data[1]", joy_data[1], 1'b0);
        pad_edge(0);
        @(negedge clk);
        check_value("o_joy_data[0]", joy_data[0], 1'b0);   // B bit
    endtask

    initial begin
        sys_resetn = 1'b0;
        rv_valid   = 1'b0;
        rv_req     = '0;
        pad        = '0;
        btns[0]    = '0;
        btns[1]    = '0;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i == 2) sys_resetn <= 1'b1;
            @(negedge clk);
            check_idle();
        end
        @(negedge clk);
        check_idle();

        // full words, write then read back
        for (int i = 0; i < 20; i++) begin
            stim_rnd = xorshift(stim_rnd);
            rv_access(stim_rnd[22:0], xorshift(stim_rnd), 4'b1111, 2, rdata);
            rv_access(stim_rnd[22:0], 32'h0, 4'b0000, 2, rdata);
            check_value("o_rv_rdata", rdata, xorshift(stim_rnd));
        end

        // half-word writes take one transaction
        rv_access(23'h012340, 32'h1111_2222, 4'b1111, 2, rdata);
        rv_access(23'h012340, 32'haaaa_bbbb, 4'b0011, 1, rdata);
        rv_access(23'h012340, 32'h0, 4'b0000, 2, rdata);
        check_value("o_rv_rdata", rdata, 32'h1111_bbbb);
        rv_access(23'h012340, 32'hcccc_dddd, 4'b1100, 1, rdata);
        rv_access(23'h012340, 32'h0, 4'b0000, 2, rdata);
        check_value("o_rv_rdata", rdata, 32'hcccc_bbbb);

        for (int r = 0; r < 4; r++) begin
            @(posedge clk);
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                stim_rnd    = xorshift(stim_rnd);
                btns[p]    <= stim_rnd[11:0] & 12'hcff;   // autofire released
                exp_byte[p] = stim_rnd[7:0];
            end
            read_pads();
        end

        @(posedge clk);
        btns[0] <= 12'h100;   // autofire A on player 0 only
        btns[1] <= '0;
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        repeat (40) begin
            sample_fire(fire_a);
            seen_hi = seen_hi | fire_a;
            seen_lo = seen_lo | !fire_a;
        end
        assert (seen_hi && seen_lo) else
            abort_run("autofire A did not show both levels while held");
        @(posedge clk);
        btns[0] <= '0;
        repeat (10) begin
            sample_fire(fire_a);
            check_value("o_joy_data[0]", fire_a, 1'b0);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sim.f */
nes_glue_pkg.sv
autofire.sv
joypad_port.sv
word_bridge.sv
nes_glue_top.sv
tb_mem_model.sv
tb_nes_glue.sv

/* Bender.yml */
package:
  name: nes_glue

sources:
  - nes_glue_pkg.sv
  - autofire.sv
  - joypad_port.sv
  - word_bridge.sv
  - nes_glue_top.sv
  - target: simulation
    files:
      - tb_mem_model.sv
      - tb_nes_glue.sv
